// ==== common/spi_slave_cfg.svh ====
`ifndef SPI_SLAVE_CFG_SVH
`define SPI_SLAVE_CFG_SVH

// field widths in bits
`define SPI_CTRL_W 8    // command byte
`define SPI_ADDR_W 8    // register address
`define SPI_DATA_W 24   // one burst word
`define SPI_LEN_W  32   // burst word count

// command codes seen in the first byte of a frame
`define SPI_CMD_WRITE 8'h3a
`define SPI_CMD_READ  8'h3b

// flops per pin before edge detection
`define SPI_SYNC_STAGES 2

`endif

// ==== common/spi_word_pkg.sv ====
`include "spi_slave_cfg.svh"

package spi_word_pkg;

  // bit index must reach the msb of the widest field
  // data is the widest one
  localparam int SPI_IDX_W = $clog2(`SPI_DATA_W);

  typedef logic [`SPI_CTRL_W-1:0] ctrl_t;  // command byte
  typedef logic [`SPI_ADDR_W-1:0] addr_t;  // register address
  typedef logic [`SPI_DATA_W-1:0] data_t;  // one data word
  typedef logic [`SPI_LEN_W-1:0]  len_t;   // words per burst

  // counts down from field msb to 0
  typedef logic [SPI_IDX_W-1:0] bit_idx_t;

endpackage

// ==== common/spi_proto_pkg.sv ====
package spi_proto_pkg;

  // frame sequencing
  // wait_ready is left once the memory side reports calibration done
  typedef enum logic [2:0] {
    st_wait_ready = 3'd0,  // memory not ready yet
    st_cmd        = 3'd1,  // receiving command byte
    st_addr       = 3'd2,  // receiving address byte
    st_write      = 3'd3,  // data words from master
    st_read       = 3'd4,  // data words to master
    st_stop       = 3'd5   // one cycle, frame complete
  } frame_state_e;

  // result of decoding the command byte
  typedef enum logic [1:0] {
    cmd_write = 2'd0,
    cmd_read  = 2'd1,
    cmd_bad   = 2'd2   // anything else aborts to command reception
  } cmd_kind_e;

endpackage

// ==== hdl/spi_pin_sync.sv ====
`timescale 1ns/100ps
`include "spi_slave_cfg.svh"

module spi_pin_sync (
  input  logic clock,
  input  logic reset,
  input  logic sclk,       // async pins from the master
  input  logic cs_n,
  input  logic mosi,
  output logic cs_active,  // synced chip select, high when selected
  output logic sample,     // one cycle per rising sclk
  output logic mosi_bit    // data bit aligned with sample
);

  // pin vector order is sclk, cs_n, mosi
  localparam logic [2:0] PIN_IDLE = 3'b010;  // deselected with sclk low

  logic [`SPI_SYNC_STAGES-1:0][2:0] pin_q;  // synchronizer chain for all three pins
  logic [2:0] pin_s;                        // last synchronizer stage
  logic       sclk_dly;                     // extra sclk stage for edge detect

  assign pin_s = pin_q[`SPI_SYNC_STAGES-1];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pin_q     <= {`SPI_SYNC_STAGES{PIN_IDLE}};
      sclk_dly  <= 1'b0;
      cs_active <= 1'b0;  // cs_n starts inactive
      sample    <= 1'b0;
      mosi_bit  <= 1'b0;
    end else begin
      pin_q    <= {pin_q[`SPI_SYNC_STAGES-2:0], {sclk, cs_n, mosi}};
      sclk_dly <= pin_s[2];
      // registered so every output lands 3 clocks after the pin edge
      sample    <= pin_s[2] & ~sclk_dly;  // mode 0 rising edge
      cs_active <= ~pin_s[1];
      mosi_bit  <= pin_s[0];              // stable around rising sclk in mode 0
    end
  end

  // master keeps sclk idle while deselected
  // a settled deselect must never see a sample strobe
  a_no_sample_deselected: assert property (
    @(posedge clock) disable iff (reset)
    !cs_active ##1 !cs_active |-> !sample
  ) else $error("sample strobe while chip select is inactive");

endmodule

// ==== spi_frame/spi_frame_ctrl.sv ====
`timescale 1ns/100ps
`include "spi_slave_cfg.svh"

module spi_frame_ctrl (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        mem_ready,   // calibration pass from memory side
  input  logic                        cs_active,
  input  logic                        sample,
  input  spi_proto_pkg::cmd_kind_e    cmd_kind,    // decoded in the shifter
  input  spi_word_pkg::len_t          burst_len,
  input  spi_word_pkg::data_t         tx_data,
  output spi_proto_pkg::frame_state_e state,
  output spi_word_pkg::bit_idx_t      bit_idx,
  output logic                        field_done,
  output logic                        frame_end,
  output logic                        tx_en,
  output logic                        miso
);

  import spi_proto_pkg::*;
  import spi_word_pkg::*;

  // reload values for msb first on the wire
  localparam bit_idx_t CTRL_MSB = bit_idx_t'(`SPI_CTRL_W - 1);
  localparam bit_idx_t ADDR_MSB = bit_idx_t'(`SPI_ADDR_W - 1);
  localparam bit_idx_t DATA_MSB = bit_idx_t'(`SPI_DATA_W - 1);

  len_t word_cnt;   // words already finished in this burst
  logic in_field;   // a state that consumes sclk bits
  logic last_word;

  assign in_field = (state == st_cmd) || (state == st_addr) ||
                    (state == st_write) || (state == st_read);

  // sample of bit 0 closes the current field or word
  assign field_done = sample && cs_active && in_field && (bit_idx == '0);

  assign last_word = (word_cnt == burst_len - 1'b1);
  assign frame_end = (state == st_stop);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= st_wait_ready;
      bit_idx  <= CTRL_MSB;
      word_cnt <= '0;
    end else if (state == st_wait_ready) begin
      // join only between frames so no half command is taken
      if (mem_ready && !cs_active) begin
        state <= st_cmd;
      end
    end else if (!cs_active) begin
      // deselect aborts whatever is in flight
      state    <= st_cmd;
      bit_idx  <= CTRL_MSB;
      word_cnt <= '0;
    end else if (field_done) begin
      case (state)
        st_cmd: begin
          state   <= st_addr;
          bit_idx <= ADDR_MSB;
        end
        st_addr: begin
          bit_idx <= DATA_MSB;
          case (cmd_kind)
            cmd_write: state <= st_write;
            cmd_read:  state <= st_read;
            default: begin
              state   <= st_cmd;   // unknown command
              bit_idx <= CTRL_MSB;
            end
          endcase
        end
        default: begin
          // write or read word finished
          bit_idx <= DATA_MSB;
          if (last_word) begin
            state    <= st_stop;
            word_cnt <= '0;
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end
      endcase
    end else if (sample && in_field) begin
      bit_idx <= bit_idx - 1'b1;  // next bit down
    end else if (state == st_stop) begin
      state   <= st_cmd;          // ready for the next frame
      bit_idx <= CTRL_MSB;
    end
  end

  // first fetch at end of address and one more per word except the last
  assign tx_en = field_done &&
                 (((state == st_addr) && (cmd_kind == cmd_read)) ||
                  ((state == st_read) && !last_word));

  // host holds tx_data for the whole word
  // bit_idx moves on each rising edge so the next bit is out before falling sclk
  assign miso = (state == st_read) ? tx_data[bit_idx] : 1'b0;

  // a burst needs at least one word
  a_burst_nonzero: assert property (
    @(posedge clock) disable iff (reset)
    field_done && (state == st_addr) && (cmd_kind != cmd_bad) |-> burst_len != '0
  ) else $error("burst_len is zero at start of data phase");

  // fetch only under a read command so never during a write burst
  a_tx_en_read_only: assert property (
    @(posedge clock) disable iff (reset)
    tx_en |-> (cmd_kind == cmd_read)
  ) else $error("tx_en outside a read burst");

endmodule

// ==== spi_frame/spi_rx_shift.sv ====
`timescale 1ns/100ps
`include "spi_slave_cfg.svh"

module spi_rx_shift (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        cs_active,
  input  logic                        sample,
  input  logic                        mosi_bit,
  input  spi_proto_pkg::frame_state_e state,
  input  spi_word_pkg::bit_idx_t      bit_idx,
  input  logic                        field_done,
  input  logic                        frame_end,
  output spi_proto_pkg::cmd_kind_e    cmd_kind,
  output spi_word_pkg::ctrl_t         ctrl,      // last completed command
  output spi_word_pkg::addr_t         address,   // last completed address
  output spi_word_pkg::data_t         rx_data,
  output logic                        rx_en,
  output logic                        spi_done
);

  import spi_proto_pkg::*;
  import spi_word_pkg::*;

  // index bits needed for the byte fields
  localparam int CTRL_IW = $clog2(`SPI_CTRL_W);
  localparam int ADDR_IW = $clog2(`SPI_ADDR_W);

  ctrl_t cmd_q;    // command being received
  addr_t addr_q;   // address being received
  data_t data_q;   // data word being received
  logic  word_done;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cmd_q  <= '0;
      addr_q <= '0;
      data_q <= '0;
    end else if (!cs_active) begin
      cmd_q  <= '0;  // start each frame from a clean slate
      addr_q <= '0;
      data_q <= '0;
    end else if (sample) begin
      case (state)
        st_cmd:   cmd_q[bit_idx[CTRL_IW-1:0]]  <= mosi_bit;
        st_addr:  addr_q[bit_idx[ADDR_IW-1:0]] <= mosi_bit;
        st_write: data_q[bit_idx]              <= mosi_bit;
        default:  ;  // read and idle states take nothing from mosi
      endcase
    end
  end

  // only place the command byte is interpreted
  always_comb begin
    case (cmd_q)
      `SPI_CMD_WRITE: cmd_kind = cmd_write;
      `SPI_CMD_READ:  cmd_kind = cmd_read;
      default:        cmd_kind = cmd_bad;
    endcase
  end

  assign word_done = field_done && (state == st_write);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_data  <= '0;
      rx_en    <= 1'b0;
      ctrl     <= '0;
      address  <= '0;
      spi_done <= 1'b0;
    end else begin
      rx_en    <= word_done;
      spi_done <= frame_end;
      if (word_done) begin
        // bit 0 arrives in this cycle and is not in data_q yet
        rx_data <= {data_q[`SPI_DATA_W-1:1], mosi_bit};
      end
      if (frame_end) begin
        ctrl    <= cmd_q;   // updates together with spi_done
        address <= addr_q;
      end
    end
  end

  // words are at least one sclk period apart
  a_rx_en_single: assert property (
    @(posedge clock) disable iff (reset)
    rx_en |=> !rx_en
  ) else $error("rx_en high on two consecutive cycles");

endmodule

// ==== hdl/spi_slave_top.sv ====
`timescale 1ns/100ps

module spi_slave_top (
  input  logic                clock,
  input  logic                reset,
  // memory host side
  input  logic                mem_ready,  // calibration pass
  input  spi_word_pkg::len_t  burst_len,
  input  spi_word_pkg::data_t tx_data,    // word for the current read fetch
  output spi_word_pkg::ctrl_t ctrl,
  output spi_word_pkg::addr_t address,
  output logic                tx_en,      // request next read word
  output logic                rx_en,      // rx_data valid this cycle
  output spi_word_pkg::data_t rx_data,
  output logic                spi_done,
  // spi pins, mode 0
  input  logic                sclk,
  input  logic                cs_n,
  input  logic                mosi,
  output logic                miso
);

  import spi_proto_pkg::*;
  import spi_word_pkg::*;

  // synchronizer to frame logic
  logic cs_active;
  logic sample;
  logic mosi_bit;

  // frame control to shifter and back
  frame_state_e state;
  bit_idx_t     bit_idx;
  cmd_kind_e    cmd_kind;
  logic         field_done;
  logic         frame_end;

  spi_pin_sync u_pin_sync (
    .clock     (clock),
    .reset     (reset),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .cs_active (cs_active),
    .sample    (sample),
    .mosi_bit  (mosi_bit)
  );

  spi_frame_ctrl u_frame_ctrl (
    .clock      (clock),
    .reset      (reset),
    .mem_ready  (mem_ready),
    .cs_active  (cs_active),
    .sample     (sample),
    .cmd_kind   (cmd_kind),
    .burst_len  (burst_len),
    .tx_data    (tx_data),
    .state      (state),
    .bit_idx    (bit_idx),
    .field_done (field_done),
    .frame_end  (frame_end),
    .tx_en      (tx_en),
    .miso       (miso)
  );

  spi_rx_shift u_rx_shift (
    .clock      (clock),
    .reset      (reset),
    .cs_active  (cs_active),
    .sample     (sample),
    .mosi_bit   (mosi_bit),
    .state      (state),
    .bit_idx    (bit_idx),
    .field_done (field_done),
    .frame_end  (frame_end),
    .cmd_kind   (cmd_kind),
    .ctrl       (ctrl),
    .address    (address),
    .rx_data    (rx_data),
    .rx_en      (rx_en),
    .spi_done   (spi_done)
  );

endmodule

// ==== test/spi_master_tasks.svh ====
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// mode 0 master, sclk idles low, data changes on falling sclk
localparam int HALF_CLKS = 8;   // system clocks per sclk half period
localparam int GAP_CLKS  = 16;  // deselect time between frames

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

// one sclk period, entered on a rising clock with sclk low
task automatic xfer_bit(input logic out_bit, output logic in_bit);
  mosi <= out_bit;                     // set up while sclk is low
  repeat (HALF_CLKS - 1) @(posedge clock);
  @(negedge clock);
  in_bit = miso;                       // value the master sees at its rising edge
  @(posedge clock);
  sclk <= 1'b1;
  repeat (HALF_CLKS) @(posedge clock);
  sclk <= 1'b0;                        // falling edge
endtask

// nbits of out_w, msb first, returns what came back on miso
task automatic shift_bits(input data_t out_w, input int nbits, output data_t in_w);
  logic b;
  in_w = '0;
  for (int i = nbits - 1; i >= 0; i--) begin
    xfer_bit(out_w[i], b);
    in_w[i] = b;
  end
endtask

task automatic select_slave();
  @(posedge clock);
  cs_n <= 1'b0;
endtask

task automatic release_slave();
  repeat (HALF_CLKS) @(posedge clock);
  cs_n <= 1'b1;
  mosi <= 1'b0;
  repeat (GAP_CLKS) @(posedge clock);  // slave falls back to command reception
endtask

// full frame, data words from wr_words, miso words into rd_words
task automatic run_frame(input ctrl_t c, input addr_t a, input int nwords);
  data_t dummy;
  select_slave();
  shift_bits(data_t'(c), `SPI_CTRL_W, dummy);
  shift_bits(data_t'(a), `SPI_ADDR_W, dummy);
  for (int i = 0; i < nwords; i++) begin
    shift_bits(wr_words[i], `SPI_DATA_W, rd_words[i]);
  end
  release_slave();
endtask

`endif

// ==== test/tb_spi_slave.sv ====
`timescale 1ns/100ps
`include "spi_slave_cfg.svh"

module tb_spi_slave;

  import spi_word_pkg::*;

  localparam int MAX_WORDS  = 8;
  localparam int DONE_WAIT  = 200;  // clocks allowed for spi_done after a frame
  localparam int QUIET_CLKS = 64;

  logic  clock;
  logic  reset;
  logic  mem_ready;
  len_t  burst_len;
  data_t tx_data = '0;   // host side, follows host_word
  logic  sclk;
  logic  cs_n;
  logic  mosi;
  ctrl_t ctrl;
  addr_t address;
  logic  tx_en;
  logic  rx_en;
  data_t rx_data;
  logic  spi_done;
  logic  miso;

  data_t mem [0:(1 << `SPI_ADDR_W) - 1];  // host memory
  addr_t host_addr = '0;   // address of the frame in flight
  data_t host_word = '0;
  int    tx_cnt    = 0;    // tx_en pulses seen
  int    done_cnt  = 0;
  data_t rx_q[$];          // every rx_en word in order
  int    tx_base;
  int    rx_base;
  int    done_base;
  data_t wr_words [0:MAX_WORDS-1];
  data_t rd_words [0:MAX_WORDS-1];
  logic [31:0] rng;

  `include "spi_master_tasks.svh"

  spi_slave_top DUT (
    .clock    (clock),    .reset   (reset),   .mem_ready (mem_ready),
    .burst_len(burst_len), .tx_data (tx_data), .ctrl      (ctrl),
    .address  (address),  .tx_en   (tx_en),   .rx_en     (rx_en),
    .rx_data  (rx_data),  .spi_done(spi_done),
    .sclk     (sclk),     .cs_n    (cs_n),    .mosi      (mosi),
    .miso     (miso)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // host model, outputs sampled mid cycle
  always @(negedge clock) begin
    if (!reset) begin
      if (tx_en) begin
        host_word <= mem[addr_t'(host_addr + addr_t'(tx_cnt - tx_base))];  // next word
        tx_cnt    <= tx_cnt + 1;
      end
      if (rx_en) rx_q.push_back(rx_data);
      if (spi_done) done_cnt <= done_cnt + 1;
    end
  end

  always @(posedge clock) tx_data <= host_word;  // ready well before falling sclk

  function automatic data_t mem_pattern(input addr_t a);
    return {a, ~a, a ^ 8'ha5};
  endfunction

  task automatic stop_on_error();
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done_cnt == done_base) begin
      if (n == DONE_WAIT) begin
        $display("Timeout at %0t ns: spi_done did not pulse after the frame", $time);
        stop_on_error();
      end
      @(posedge clock);
      n++;
    end
  endtask

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      wr_words[i] = rng[`SPI_DATA_W-1:0];
    end
  endtask

  // snapshot of the host counters, then burst length for the next frame
  task automatic prepare_frame(input addr_t a, input int n);
    host_addr = a;
    rx_base   = rx_q.size();
    done_base = done_cnt;
    tx_base   = tx_cnt;
    @(posedge clock);
    burst_len <= len_t'(n);
  endtask

  task automatic expect_no_response(input string what);
    repeat (QUIET_CLKS) @(posedge clock);
    check_count({what, " rx_en pulses"}, rx_q.size() - rx_base, 0);
    check_count({what, " tx_en pulses"}, tx_cnt - tx_base, 0);
    check_count({what, " spi_done pulses"}, done_cnt - done_base, 0);
  endtask

  task automatic write_and_check(input addr_t a, input int n);
    prepare_frame(a, n);
    run_frame(`SPI_CMD_WRITE, a, n);
    wait_done();
    check_count("rx_en pulses", rx_q.size() - rx_base, n);
    for (int i = 0; i < n; i++) begin
      check_data($sformatf("rx_data word %0d", i), rx_q[rx_base + i], wr_words[i]);
    end
    check_count("spi_done pulses", done_cnt - done_base, 1);
    check_ctrl("ctrl", ctrl, `SPI_CMD_WRITE);
    check_addr("address", address, a);
  endtask

  task automatic test_not_ready();
    fill_random(1);
    prepare_frame(8'h21, 1);
    run_frame(`SPI_CMD_WRITE, 8'h21, 1);
    expect_no_response("before mem_ready");
    mem_ready <= 1'b1;
    repeat (4) @(posedge clock);
    write_and_check(8'h21, 1);  // same frame once ready
  endtask

  task automatic test_burst_read();
    addr_t a;
    a = 8'hfe;  // burst runs past the top address
    for (int i = 0; i < 3; i++) wr_words[i] = '0;
    prepare_frame(a, 3);
    run_frame(`SPI_CMD_READ, a, 3);
    wait_done();
    check_count("tx_en pulses", tx_cnt - tx_base, 3);
    check_count("rx_en pulses in read", rx_q.size() - rx_base, 0);
    for (int i = 0; i < 3; i++) begin
      check_data($sformatf("miso word %0d", i), rd_words[i], mem[addr_t'(a + addr_t'(i))]);
    end
    check_ctrl("ctrl", ctrl, `SPI_CMD_READ);
    check_addr("address", address, a);
  endtask

  task automatic test_bad_cmd();
    ctrl_t ctrl_prev;
    addr_t addr_prev;
    ctrl_prev   = ctrl;
    addr_prev   = address;
    wr_words[0] = '0;  // trailing bits decode as another bad command
    prepare_frame(8'h33, 1);
    run_frame(8'h55, 8'h33, 1);
    expect_no_response("unknown command");
    check_ctrl("ctrl after bad command", ctrl, ctrl_prev);
    check_addr("address after bad command", address, addr_prev);
    fill_random(2);
    write_and_check(8'h44, 2);
  endtask

  task automatic test_abort();
    data_t dummy;
    addr_t addr_prev;
    addr_prev = address;
    fill_random(1);
    prepare_frame(8'h66, 1);
    select_slave();
    shift_bits(data_t'(`SPI_CMD_WRITE), `SPI_CTRL_W, dummy);
    shift_bits(data_t'(8'h66), `SPI_ADDR_W, dummy);
    shift_bits(wr_words[0] >> 12, 12, dummy);  // upper half of the word only
    release_slave();
    expect_no_response("aborted frame");
    check_addr("address after abort", address, addr_prev);
    fill_random(3);
    write_and_check(8'h67, 3);
  endtask

  initial begin
    reset     = 1'b1;
    mem_ready = 1'b0;
    burst_len = '0;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    rng       = 32'd98936;
    for (int i = 0; i < (1 << `SPI_ADDR_W); i++) mem[i] = mem_pattern(addr_t'(i));
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);
    test_not_ready();
    fill_random(1);
    write_and_check(8'h5c, 1);  // single word
    fill_random(4);
    write_and_check(8'h90, 4);  // burst
    test_burst_read();
    test_bad_cmd();
    test_abort();
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+common
+incdir+test
common/spi_word_pkg.sv
common/spi_proto_pkg.sv
hdl/spi_pin_sync.sv
spi_frame/spi_frame_ctrl.sv
spi_frame/spi_rx_shift.sv
hdl/spi_slave_top.sv
test/tb_spi_slave.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := tb_spi_slave
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
